// File: tb.f
rtl/mipsPkg.sv
rtl/instDecoder.sv
rtl/regFile.sv
rtl/aluExecute.sv
rtl/pcUnit.sv
rtl/writeBack.sv
rtl/singleCycleMips.sv
verification/tbSingleCycleMips.sv

// File: runSim.sh
#!/bin/sh
# build and run the single-cycle MIPS testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tbSingleCycleMips -f tb.f -o simTb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/simTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

// File: verification/tbSingleCycleMips.sv
`default_nettype none

module tbSingleCycleMips;

  import mipsPkg::*;

  localparam int ramAddrWidth = 7;
  localparam int maxCycles = 200;
  // final instruction jumps to itself
  localparam wordT endAddr = 32'd124;

  logic clk;
  logic rst;
  wordT inst;
  wordT loadData;
  wordT instAddr;
  logic [ramAddrWidth-1:0] dataAddr;
  wordT storeData;
  logic memWen;
  logic regWriteEn;
  wordT regWriteData;

  // memory models
  wordT rom [256];
  wordT ram [1 << ramAddrWidth];

  // shadow state of the reference model
  wordT shadowRegs [32];
  wordT shadowRam [1 << ramAddrWidth];
  wordT shadowPc;

  // expected values for the current instruction
  wordT refA;
  wordT refB;
  wordT refImm;
  wordT refAddr;
  logic expRegWen;
  regAddrT expWaddr;
  wordT expWdata;
  logic expMemWen;
  logic [ramAddrWidth-1:0] expDataAddr;
  wordT expStore;
  wordT expNextPc;

  int errorCount = 0;
  int timeoutCount = 0;
  int retired = 0;

  singleCycleMips #(
    .dataAddrWidth (ramAddrWidth)
  ) uut (
    .clk          (clk),
    .rst          (rst),
    .inst         (inst),
    .loadData     (loadData),
    .instAddr     (instAddr),
    .dataAddr     (dataAddr),
    .storeData    (storeData),
    .memWen       (memWen),
    .regWriteEn   (regWriteEn),
    .regWriteData (regWriteData)
  );

  always #50 clk = ~clk;

  // ========================================
  // helpers
  // ========================================

  function automatic wordT nextRandom(input wordT s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic wordT rTypeWord(input regAddrT rs, input regAddrT rt,
                                     input regAddrT rd, input functT fn);
    return {opRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic wordT iTypeWord(input opcodeT op, input regAddrT rs,
                                     input regAddrT rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic wordT jTypeWord(input opcodeT op, input logic [25:0] idx);
    return {op, idx};
  endfunction

  task automatic reportMismatch(input string name, input wordT got, input wordT exp);
    $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
    errorCount++;
  endtask

  // ========================================
  // memories and program
  // ========================================

  // combinational read ports
  assign inst = rom[instAddr[9:2]];
  assign loadData = ram[dataAddr];

  // store on the edge, active-low strobe
  always @(posedge clk) begin
    if (!memWen) begin
      ram[dataAddr] <= storeData;
    end
  end

  initial begin
    wordT state;
    state = 32'd64;
    for (int i = 0; i < (1 << ramAddrWidth); i++) begin
      state = nextRandom(state);
      ram[i] = state;
      shadowRam[i] = state;
    end
    // all-zero word is a no-op
    for (int i = 0; i < 256; i++) begin
      rom[i] = '0;
    end
    // random operands from words 0..2
    rom[1]  = iTypeWord(opLw, 5'd0, 5'd1, 16'd0);
    rom[2]  = iTypeWord(opLw, 5'd0, 5'd2, 16'd4);
    rom[3]  = iTypeWord(opLw, 5'd0, 5'd3, 16'd8);
    rom[4]  = rTypeWord(5'd1, 5'd2, 5'd4, fnAdd);
    rom[5]  = rTypeWord(5'd1, 5'd2, 5'd5, fnSub);
    rom[6]  = rTypeWord(5'd1, 5'd2, 5'd6, fnAnd);
    rom[7]  = rTypeWord(5'd1, 5'd2, 5'd7, fnOr);
    // r8 = -r1, so one slt operand is negative
    rom[8]  = rTypeWord(5'd0, 5'd1, 5'd8, fnSub);
    rom[9]  = rTypeWord(5'd8, 5'd1, 5'd9, fnSlt);
    rom[10] = rTypeWord(5'd1, 5'd8, 5'd10, fnSlt);
    rom[11] = rTypeWord(5'd2, 5'd3, 5'd11, fnSlt);
    // fixed and computed store addresses, then read back
    rom[12] = iTypeWord(opSw, 5'd0, 5'd4, 16'd40);
    rom[13] = iTypeWord(opSw, 5'd3, 5'd5, 16'd8);
    rom[14] = iTypeWord(opLw, 5'd0, 5'd12, 16'd40);
    rom[15] = iTypeWord(opLw, 5'd3, 5'd13, 16'd8);
    // write to r0, then read it through an add
    rom[16] = rTypeWord(5'd1, 5'd2, 5'd0, fnAdd);
    rom[17] = rTypeWord(5'd0, 5'd1, 5'd14, fnAdd);
    // taken beq skips 19 and 20
    rom[18] = iTypeWord(opBeq, 5'd1, 5'd1, 16'd2);
    rom[19] = rTypeWord(5'd1, 5'd1, 5'd15, fnAdd);
    rom[20] = rTypeWord(5'd2, 5'd2, 5'd15, fnAdd);
    rom[21] = iTypeWord(opBeq, 5'd1, 5'd2, 16'd5);
    rom[22] = jTypeWord(opJ, 26'd25);
    rom[23] = rTypeWord(5'd1, 5'd2, 5'd16, fnAdd);
    rom[25] = jTypeWord(opJal, 26'd28);
    // link value through r31
    rom[28] = rTypeWord(5'd31, 5'd0, 5'd16, fnAdd);
    // funct 0x08 and opcode 0x08 are not supported
    rom[29] = rTypeWord(5'd1, 5'd2, 5'd17, 6'h08);
    rom[30] = iTypeWord(6'h08, 5'd1, 5'd18, 16'd5);
    rom[31] = jTypeWord(opJ, 26'd31);
  end

  // ========================================
  // reference model
  // ========================================

  always_comb begin
    refA = shadowRegs[inst[25:21]];
    refB = shadowRegs[inst[20:16]];
    refImm = {{16{inst[15]}}, inst[15:0]};
    refAddr = refA + refImm;
    expRegWen = 1'b0;
    expWaddr = inst[15:11];
    expWdata = '0;
    expMemWen = 1'b1;
    expDataAddr = refAddr[ramAddrWidth+1:2];
    expStore = refB;
    expNextPc = shadowPc + 32'd4;
    case (inst[31:26])
      opRType: begin
        expRegWen = 1'b1;
        case (inst[5:0])
          fnAdd: expWdata = refA + refB;
          fnSub: expWdata = refA - refB;
          fnAnd: expWdata = refA & refB;
          fnOr:  expWdata = refA | refB;
          fnSlt: expWdata = {31'd0, ($signed(refA) < $signed(refB))};
          default: expRegWen = 1'b0;
        endcase
      end
      opLw: begin
        expRegWen = 1'b1;
        expWaddr = inst[20:16];
        expWdata = shadowRam[expDataAddr];
      end
      opSw: expMemWen = 1'b0;
      opBeq: begin
        if (refA == refB) begin
          expNextPc = shadowPc + 32'd4 + {refImm[29:0], 2'b00};
        end
      end
      opJ: expNextPc = {expNextPc[31:28], inst[25:0], 2'b00};
      opJal: begin
        // return address is the next instruction
        expRegWen = 1'b1;
        expWaddr = linkReg;
        expWdata = shadowPc + 32'd4;
        expNextPc = {expNextPc[31:28], inst[25:0], 2'b00};
      end
      default: expRegWen = 1'b0;
    endcase
  end

  // shadow state retires one instruction per edge
  always @(posedge clk or negedge rst) begin
    if (!rst) begin
      shadowPc <= '0;
      for (int i = 0; i < 32; i++) begin
        shadowRegs[i] <= '0;
      end
    end else begin
      if (expRegWen && (expWaddr != '0)) begin
        shadowRegs[expWaddr] <= expWdata;
      end
      if (!expMemWen) begin
        shadowRam[expDataAddr] <= expStore;
      end
      shadowPc <= expNextPc;
      retired <= retired + 1;
    end
  end

  // ========================================
  // checks
  // ========================================

  // in reset and one cycle after
  checkResetPc : assert property (@(posedge clk) (!rst || !$past(rst)) |-> instAddr == '0)
    else reportMismatch("instAddr", $sampled(instAddr), 32'd0);
  checkResetMem : assert property (@(posedge clk) (!rst || !$past(rst)) |-> memWen)
    else reportMismatch("memWen", 32'($sampled(memWen)), 32'd1);
  checkResetReg : assert property (@(posedge clk) (!rst || !$past(rst)) |-> !regWriteEn)
    else reportMismatch("regWriteEn", 32'($sampled(regWriteEn)), 32'd0);

  checkPc : assert property (@(posedge clk) disable iff (!rst) instAddr == shadowPc)
    else reportMismatch("instAddr", $sampled(instAddr), $sampled(shadowPc));
  checkRegWen : assert property (@(posedge clk) disable iff (!rst) regWriteEn == expRegWen)
    else reportMismatch("regWriteEn", 32'($sampled(regWriteEn)), 32'($sampled(expRegWen)));
  checkRegData : assert property (
    @(posedge clk) disable iff (!rst) expRegWen |-> regWriteData == expWdata
  ) else reportMismatch("regWriteData", $sampled(regWriteData), $sampled(expWdata));
  checkMemWen : assert property (@(posedge clk) disable iff (!rst) memWen == expMemWen)
    else reportMismatch("memWen", 32'($sampled(memWen)), 32'($sampled(expMemWen)));
  checkDataAddr : assert property (
    @(posedge clk) disable iff (!rst) !expMemWen |-> dataAddr == expDataAddr
  ) else reportMismatch("dataAddr", 32'($sampled(dataAddr)), 32'($sampled(expDataAddr)));
  checkStoreData : assert property (
    @(posedge clk) disable iff (!rst) !expMemWen |-> storeData == expStore
  ) else reportMismatch("storeData", $sampled(storeData), $sampled(expStore));

  // ========================================
  // run control
  // ========================================

  initial begin
    int cycles;
    clk = 1'b0;
    rst = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b1;
    // program ends on its self-jump
    cycles = 0;
    while (instAddr != endAddr && cycles < maxCycles) begin
      @(negedge clk);
      cycles++;
    end
    if (instAddr != endAddr) begin
      $display("timeout: program did not reach its final self-jump in %0d cycles", maxCycles);
      timeoutCount++;
    end
    // let the self-jump itself be checked
    repeat (3) @(negedge clk);
    $display("errors %0d, timeouts %0d, instructions %0d", errorCount, timeoutCount, retired);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rtl/singleCycleMips.sv
`default_nettype none

module singleCycleMips #(
  parameter int dataAddrWidth = 7
) (
  input  logic                     clk,
  input  logic                     rst,
  input  mipsPkg::wordT            inst,
  input  mipsPkg::wordT            loadData,
  output mipsPkg::wordT            instAddr,
  output logic [dataAddrWidth-1:0] dataAddr,
  output mipsPkg::wordT            storeData,
  output logic                     memWen,
  output logic                     regWriteEn,
  output mipsPkg::wordT            regWriteData
);

  import mipsPkg::*;

  // decode outputs
  logic    regDst;
  logic    aluSrc;
  logic    memToReg;
  logic    regWrite;
  logic    memWrite;
  logic    branch;
  logic    jump;
  logic    link;
  aluCtrlT aluCtrl;
  regAddrT rs;
  regAddrT rt;
  regAddrT rd;
  logic [15:0] imm16;
  logic [25:0] jumpIndex;

  // datapath
  wordT    readData1;
  wordT    readData2;
  wordT    aluResult;
  logic    aluZero;
  wordT    branchOffset;
  wordT    pcPlus4;
  regAddrT writeAddr;

  // ========================================
  // fetch and decode
  // ========================================

  pcUnit pcUnit0 (
    .clk          (clk),
    .rst          (rst),
    .branch       (branch),
    .aluZero      (aluZero),
    .jump         (jump),
    .branchOffset (branchOffset),
    .jumpIndex    (jumpIndex),
    .pc           (instAddr),
    .pcPlus4      (pcPlus4)
  );

  instDecoder instDecoder0 (
    .inst      (inst),
    .regDst    (regDst),
    .aluSrc    (aluSrc),
    .memToReg  (memToReg),
    .regWrite  (regWrite),
    .memWrite  (memWrite),
    .branch    (branch),
    .jump      (jump),
    .link      (link),
    .aluCtrl   (aluCtrl),
    .rs        (rs),
    .rt        (rt),
    .rd        (rd),
    .imm16     (imm16),
    .jumpIndex (jumpIndex)
  );

  // ========================================
  // registers and execute
  // ========================================

  regFile regFile0 (
    .clk       (clk),
    .rst       (rst),
    .writeEn   (regWriteEn),
    .readAddr1 (rs),
    .readAddr2 (rt),
    .writeAddr (writeAddr),
    .writeData (regWriteData),
    .readData1 (readData1),
    .readData2 (readData2)
  );

  aluExecute #(
    .dataAddrWidth (dataAddrWidth)
  ) aluExecute0 (
    .operandA     (readData1),
    .operandB     (readData2),
    .imm16        (imm16),
    .aluSrc       (aluSrc),
    .aluCtrl      (aluCtrl),
    .aluResult    (aluResult),
    .aluZero      (aluZero),
    .branchOffset (branchOffset),
    .dataAddr     (dataAddr)
  );

  // ========================================
  // result and memory side
  // ========================================

  writeBack writeBack0 (
    .regWrite  (regWrite),
    .regDst    (regDst),
    .memToReg  (memToReg),
    .link      (link),
    .rt        (rt),
    .rd        (rd),
    .aluResult (aluResult),
    .loadData  (loadData),
    .pcPlus4   (pcPlus4),
    .writeEn   (regWriteEn),
    .writeAddr (writeAddr),
    .writeData (regWriteData)
  );

  // rt value is the store data
  assign storeData = readData2;

  // active-low write strobe to data memory
  assign memWen = ~memWrite;

endmodule

`default_nettype wire

// File: rtl/writeBack.sv
`default_nettype none

module writeBack (
  input  logic             regWrite,
  input  logic             regDst,
  input  logic             memToReg,
  input  logic             link,
  input  mipsPkg::regAddrT rt,
  input  mipsPkg::regAddrT rd,
  input  mipsPkg::wordT    aluResult,
  input  mipsPkg::wordT    loadData,
  input  mipsPkg::wordT    pcPlus4,
  output logic             writeEn,
  output mipsPkg::regAddrT writeAddr,
  output mipsPkg::wordT    writeData
);

  import mipsPkg::*;

  // ========================================
  // destination and value
  // ========================================

  assign writeEn = regWrite;

  // jal to r31, R-type to rd, lw to rt
  assign writeAddr = link ? linkReg : (regDst ? rd : rt);

  // return address, load word or ALU result
  always_comb begin
    if (link) begin
      writeData = pcPlus4;
    end else if (memToReg) begin
      writeData = loadData;
    end else begin
      writeData = aluResult;
    end
  end

endmodule

`default_nettype wire

// File: rtl/pcUnit.sv
`default_nettype none

module pcUnit (
  input  logic          clk,
  input  logic          rst,
  input  logic          branch,
  input  logic          aluZero,
  input  logic          jump,
  input  mipsPkg::wordT branchOffset,
  input  logic [25:0]   jumpIndex,
  output mipsPkg::wordT pc,
  output mipsPkg::wordT pcPlus4
);

  import mipsPkg::*;

  wordT jumpTarget;
  wordT branchTarget;
  wordT nextPc;

  // ========================================
  // next PC select
  // ========================================

  assign pcPlus4 = pc + 32'd4;

  // region bits of pcPlus4, then index, then word offset
  assign jumpTarget = {pcPlus4[31:28], jumpIndex, 2'b00};

  // relative to the following instruction
  assign branchTarget = pcPlus4 + branchOffset;

  // jump wins over a taken branch
  always_comb begin
    if (jump) begin
      nextPc = jumpTarget;
    end else if (branch && aluZero) begin
      nextPc = branchTarget;
    end else begin
      nextPc = pcPlus4;
    end
  end

  // ========================================
  // PC register
  // ========================================

  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      pc <= '0;
    end else begin
      pc <= nextPc;
    end
  end

  // holds across branches and jumps
  assertPcAligned : assert property (
    @(posedge clk) disable iff (!rst) pc[1:0] == 2'b00
  ) else $error("pcUnit: pc %h not word aligned", pc);

endmodule

`default_nettype wire

// File: rtl/aluExecute.sv
`default_nettype none

module aluExecute #(
  parameter int dataAddrWidth = 7
) (
  input  mipsPkg::wordT          operandA,
  input  mipsPkg::wordT          operandB,
  input  logic [15:0]            imm16,
  input  logic                   aluSrc,
  input  mipsPkg::aluCtrlT       aluCtrl,
  output mipsPkg::wordT          aluResult,
  output logic                   aluZero,
  output mipsPkg::wordT          branchOffset,
  output logic [dataAddrWidth-1:0] dataAddr
);

  import mipsPkg::*;

  wordT immExt;
  wordT aluIn2;

  // ========================================
  // operand select
  // ========================================

  // sign extension of the 16-bit field
  assign immExt = {{16{imm16[15]}}, imm16};

  // immediate for lw/sw, register otherwise
  assign aluIn2 = aluSrc ? immExt : operandB;

  // byte offset of beq, counted in words
  assign branchOffset = {immExt[29:0], 2'b00};

  // ========================================
  // ALU
  // ========================================

  always_comb begin
    case (aluCtrl)
      aluAnd: aluResult = operandA & aluIn2;
      aluOr:  aluResult = operandA | aluIn2;
      aluAdd: aluResult = operandA + aluIn2;
      aluSub: aluResult = operandA - aluIn2;
      // signed compare, result is 0 or 1
      aluSlt: aluResult = ($signed(operandA) < $signed(aluIn2)) ? 32'd1 : 32'd0;
      // aluNone and any other code
      default: aluResult = '0;
    endcase
  end

  // equal operands for beq
  assign aluZero = (aluResult == '0);

  // word address into data memory, byte bits dropped
  assign dataAddr = aluResult[dataAddrWidth+1:2];

endmodule

`default_nettype wire

// File: rtl/regFile.sv
`default_nettype none

module regFile (
  input  logic             clk,
  input  logic             rst,
  input  logic             writeEn,
  input  mipsPkg::regAddrT readAddr1,
  input  mipsPkg::regAddrT readAddr2,
  input  mipsPkg::regAddrT writeAddr,
  input  mipsPkg::wordT    writeData,
  output mipsPkg::wordT    readData1,
  output mipsPkg::wordT    readData2
);

  import mipsPkg::*;

  // 32 general purpose registers
  wordT regs [32];

  // ========================================
  // write port
  // ========================================

  // reset clears every entry
  always_ff @(posedge clk or negedge rst) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    // writes aimed at r0 are dropped
    end else if (writeEn && (writeAddr != '0)) begin
      regs[writeAddr] <= writeData;
    end
  end

  // ========================================
  // read ports
  // ========================================

  // combinational reads with r0 hardwired to zero
  assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
  assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

  // r0 storage stays zero even after a write aimed at it
  assertR0Zero : assert property (
    @(posedge clk) disable iff (!rst) regs[0] == '0
  ) else $error("regFile: r0 storage nonzero, value %h", regs[0]);

endmodule

`default_nettype wire

// File: rtl/instDecoder.sv
`default_nettype none

module instDecoder (
  input  mipsPkg::wordT    inst,
  output logic             regDst,
  output logic             aluSrc,
  output logic             memToReg,
  output logic             regWrite,
  output logic             memWrite,
  output logic             branch,
  output logic             jump,
  output logic             link,
  output mipsPkg::aluCtrlT aluCtrl,
  output mipsPkg::regAddrT rs,
  output mipsPkg::regAddrT rt,
  output mipsPkg::regAddrT rd,
  output logic [15:0]      imm16,
  output logic [25:0]      jumpIndex
);

  import mipsPkg::*;

  opcodeT opcode;
  functT  funct;

  // ========================================
  // instruction fields
  // ========================================

  assign opcode    = inst[31:26];
  assign funct     = inst[5:0];
  assign rs        = inst[25:21];
  assign rt        = inst[20:16];
  assign rd        = inst[15:11];
  assign imm16     = inst[15:0];
  assign jumpIndex = inst[25:0];

  // ========================================
  // control decode
  // ========================================

  // main control and ALU control in one step
  always_comb begin
    // defaults describe a no-op
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memToReg = 1'b0;
    regWrite = 1'b0;
    memWrite = 1'b0;
    branch   = 1'b0;
    jump     = 1'b0;
    link     = 1'b0;
    aluCtrl  = aluNone;
    case (opcode)
      opRType: begin
        regDst = 1'b1;
        // funct picks the operation
        case (funct)
          fnAdd: aluCtrl = aluAdd;
          fnSub: aluCtrl = aluSub;
          fnAnd: aluCtrl = aluAnd;
          fnOr:  aluCtrl = aluOr;
          fnSlt: aluCtrl = aluSlt;
          default: aluCtrl = aluNone;
        endcase
        // unknown funct, incl. the all-zero word, writes nothing
        regWrite = (aluCtrl != aluNone);
      end
      opLw: begin
        // base plus offset
        aluSrc   = 1'b1;
        memToReg = 1'b1;
        regWrite = 1'b1;
        aluCtrl  = aluAdd;
      end
      opSw: begin
        aluSrc   = 1'b1;
        memWrite = 1'b1;
        aluCtrl  = aluAdd;
      end
      opBeq: begin
        // equality through subtract and zero flag
        branch  = 1'b1;
        aluCtrl = aluSub;
      end
      opJ: begin
        jump = 1'b1;
      end
      opJal: begin
        // jump and write return address
        jump     = 1'b1;
        link     = 1'b1;
        regWrite = 1'b1;
      end
      default: begin
        // unsupported opcode, all controls stay low
        aluCtrl = aluNone;
      end
    endcase
  end

  // a store never also writes the register file
  always_comb begin
    assert (!(memWrite && regWrite))
      else $error("instDecoder: memWrite and regWrite both set, inst %h", inst);
  end

endmodule

`default_nettype wire

// File: rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

  // ========================================
  // word and field types
  // ========================================

  // data and address word
  typedef logic [31:0] wordT;
  // register index, 32 entries
  typedef logic [4:0] regAddrT;
  // instruction bits 31:26
  typedef logic [5:0] opcodeT;
  // instruction bits 5:0, R-type only
  typedef logic [5:0] functT;
  // ALU operation code
  typedef logic [3:0] aluCtrlT;

  // ========================================
  // opcodes
  // ========================================

  localparam opcodeT opRType = 6'b000000;
  localparam opcodeT opLw = 6'b100011;
  localparam opcodeT opSw = 6'b101011;
  localparam opcodeT opBeq = 6'b000100;
  localparam opcodeT opJ = 6'b000010;
  localparam opcodeT opJal = 6'b000011;

  // funct field of the R-type ops
  localparam functT fnAdd = 6'b100000;
  localparam functT fnSub = 6'b100010;
  localparam functT fnAnd = 6'b100100;
  localparam functT fnOr = 6'b100101;
  localparam functT fnSlt = 6'b101010;

  // ========================================
  // ALU codes
  // ========================================

  localparam aluCtrlT aluAnd = 4'b0000;
  localparam aluCtrlT aluOr = 4'b0001;
  localparam aluCtrlT aluAdd = 4'b0010;
  localparam aluCtrlT aluSub = 4'b0110;
  localparam aluCtrlT aluSlt = 4'b0111;
  // no operation, result forced to zero
  localparam aluCtrlT aluNone = 4'b1111;

  // jal return address register
  localparam regAddrT linkReg = 5'd31;

endpackage

`default_nettype wire
